// ==== hw/vga_pkg.sv ====
package vga_pkg;

    // screen position, wide enough for the full 800 x 525 raster.
    typedef logic [10:0] coord_t;

    // four bits per channel, red in the top nibble.
    typedef logic [11:0] rgb_t;

    // one pixel of the stream as it moves between drawing stages.
    typedef struct packed {
        coord_t hcount;
        coord_t vcount;
        logic   hsync;
        logic   vsync;
        logic   hblnk;
        logic   vblnk;
        rgb_t   rgb;
    } vga_px_t;

endpackage

// ==== hw/game_pkg.sv ====
package game_pkg;

    // world coordinate, signed so that moves above the top edge stay sane.
    typedef logic signed [11:0] pos_t;

    typedef struct packed {
        pos_t x;
        pos_t y;
        pos_t w;
        pos_t h;
    } rect_t;

    typedef struct packed {
        pos_t x;
        pos_t y;
    } point_t;

    localparam pos_t char_w     = 12'sd8;
    localparam pos_t char_h     = 12'sd12;
    localparam pos_t step_px    = 12'sd2;
    localparam pos_t jump_speed = 12'sd6;
    localparam pos_t max_fall   = 12'sd4;

    localparam vga_pkg::rgb_t sky_rgb    = 12'h6_a_f;
    localparam vga_pkg::rgb_t ground_rgb = 12'h7_5_3;
    localparam vga_pkg::rgb_t plat_rgb   = 12'ha_5_2;
    localparam vga_pkg::rgb_t char_rgb   = 12'hf_d_0;

    function automatic pos_t to_pos(input vga_pkg::coord_t c);
        return pos_t'({1'b0, c});
    endfunction

    function automatic logic in_rect(input pos_t x, input pos_t y, input rect_t r);
        return (x >= r.x) && (x < r.x + r.w) && (y >= r.y) && (y < r.y + r.h);
    endfunction

    // character standing at x overlaps the rectangle horizontally.
    function automatic logic spans(input pos_t x, input rect_t r);
        return (x < r.x + r.w) && (x + char_w > r.x);
    endfunction

endpackage

// ==== hw/vga_timing.sv ====
`timescale 1ns/1ps

module vga_timing #(
    parameter int h_active = 640,
    parameter int h_front  = 16,
    parameter int h_sync   = 96,
    parameter int h_back   = 48,
    parameter int v_active = 480,
    parameter int v_front  = 10,
    parameter int v_sync   = 2,
    parameter int v_back   = 33
) (
    input  logic             clk,
    input  logic             rst_n,
    output vga_pkg::vga_px_t px,
    output logic             frame_tick
);
    import vga_pkg::*;

    localparam int h_total = h_active + h_front + h_sync + h_back;
    localparam int v_total = v_active + v_front + v_sync + v_back;

    localparam coord_t h_last   = coord_t'(h_total - 1);
    localparam coord_t v_last   = coord_t'(v_total - 1);
    localparam coord_t h_blank  = coord_t'(h_active);
    localparam coord_t v_blank  = coord_t'(v_active);
    localparam coord_t hs_start = coord_t'(h_active + h_front);
    localparam coord_t hs_stop  = coord_t'(h_active + h_front + h_sync);
    localparam coord_t vs_start = coord_t'(v_active + v_front);
    localparam coord_t vs_stop  = coord_t'(v_active + v_front + v_sync);

    coord_t h_nxt;
    coord_t v_nxt;

    // next raster position.
    always_comb begin
        h_nxt = px.hcount + 1'b1;
        v_nxt = px.vcount;
        if (px.hcount == h_last) begin
            h_nxt = '0;
            if (px.vcount == v_last) begin
                v_nxt = '0;
            end else begin
                v_nxt = px.vcount + 1'b1;
            end
        end
    end

    // flags are compared on the next position so they line up with the counters.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            px         <= '0;
            frame_tick <= 1'b0;
        end else begin
            px.hcount  <= h_nxt;
            px.vcount  <= v_nxt;
            px.hsync   <= (h_nxt >= hs_start) && (h_nxt < hs_stop);
            px.vsync   <= (v_nxt >= vs_start) && (v_nxt < vs_stop);
            px.hblnk   <= (h_nxt >= h_blank);
            px.vblnk   <= (v_nxt >= v_blank);
            px.rgb     <= '0;
            frame_tick <= (h_nxt == '0) && (v_nxt == v_blank);
        end
    end

endmodule

// ==== hw/draw_bg.sv ====
`timescale 1ns/1ps

module draw_bg #(
    parameter game_pkg::pos_t floor_y = 12'sd440
) (
    input  logic             clk,
    input  logic             rst_n,
    input  vga_pkg::vga_px_t px_in,
    output vga_pkg::vga_px_t px_out
);
    import vga_pkg::*;
    import game_pkg::*;

    vga_px_t px_nxt;

    always_comb begin
        px_nxt = px_in;
        if (px_in.hblnk || px_in.vblnk) begin
            px_nxt.rgb = '0;
        end else if (to_pos(px_in.vcount) >= floor_y) begin
            px_nxt.rgb = ground_rgb;
        end else begin
            px_nxt.rgb = sky_rgb;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            px_out <= '0;
        end else begin
            px_out <= px_nxt;
        end
    end

endmodule

// ==== hw/platform.sv ====
`timescale 1ns/1ps

module platform #(
    parameter game_pkg::rect_t plat    = '{x: 12'sd256, y: 12'sd360, w: 12'sd128, h: 12'sd8},
    parameter game_pkg::pos_t  floor_y = 12'sd440
) (
    input  logic              clk,
    input  logic              rst_n,
    input  vga_pkg::vga_px_t  px_in,
    output vga_pkg::vga_px_t  px_out,
    input  game_pkg::point_t  char_pos,
    output logic              on_ground
);
    import vga_pkg::*;
    import game_pkg::*;

    vga_px_t px_nxt;
    pos_t    px_x;
    pos_t    px_y;
    pos_t    char_bottom;
    logic    on_floor;
    logic    on_plat;

    assign px_x = to_pos(px_in.hcount);
    assign px_y = to_pos(px_in.vcount);

    always_comb begin
        px_nxt = px_in;
        if (!px_in.hblnk && !px_in.vblnk && in_rect(px_x, px_y, plat)) begin
            px_nxt.rgb = plat_rgb;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            px_out <= '0;
        end else begin
            px_out <= px_nxt;
        end
    end

    // ground contact from the registered character position.
    assign char_bottom = char_pos.y + char_h;
    assign on_floor    = (char_bottom == floor_y);
    assign on_plat     = (char_bottom == plat.y) && spans(char_pos.x, plat);
    assign on_ground   = on_floor || on_plat;

endmodule

// ==== hw/char_ctl.sv ====
`timescale 1ns/1ps

module char_ctl #(
    parameter int              h_active = 640,
    parameter game_pkg::pos_t  floor_y  = 12'sd440,
    parameter game_pkg::rect_t plat     = '{x: 12'sd256, y: 12'sd360, w: 12'sd128, h: 12'sd8}
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             frame_tick,
    input  logic             stepleft,
    input  logic             stepright,
    input  logic             stepjump,
    input  logic             on_ground,
    output game_pkg::point_t char_pos
);
    import game_pkg::*;

    localparam pos_t x_max     = pos_t'(h_active) - char_w;
    localparam pos_t floor_top = floor_y - char_h;
    localparam pos_t plat_top  = plat.y - char_h;

    pos_t vy;
    pos_t vy_nxt;
    pos_t vy_land;
    pos_t x_nxt;
    pos_t y_move;
    pos_t y_nxt;

    // horizontal step, clamped to the screen.
    always_comb begin
        x_nxt = char_pos.x;
        if (stepright && !stepleft) begin
            if (char_pos.x > x_max - step_px) begin
                x_nxt = x_max;
            end else begin
                x_nxt = char_pos.x + step_px;
            end
        end else if (stepleft && !stepright) begin
            if (char_pos.x < step_px) begin
                x_nxt = '0;
            end else begin
                x_nxt = char_pos.x - step_px;
            end
        end
    end

    // velocity first, then the move it gives.
    always_comb begin
        if (on_ground && stepjump) begin
            vy_nxt = -jump_speed;
        end else if (!on_ground) begin
            vy_nxt = (vy >= max_fall) ? max_fall : vy + 12'sd1;
        end else begin
            vy_nxt = '0;
        end

        y_move  = char_pos.y + vy_nxt;
        y_nxt   = y_move;
        vy_land = vy_nxt;

        // landing only on the way down; platform is higher so it wins.
        if (vy_nxt > 0) begin
            if (spans(x_nxt, plat) && char_pos.y <= plat_top && y_move >= plat_top) begin
                y_nxt   = plat_top;
                vy_land = '0;
            end else if (char_pos.y <= floor_top && y_move >= floor_top) begin
                y_nxt   = floor_top;
                vy_land = '0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            char_pos.x <= '0;
            char_pos.y <= floor_top;
            vy         <= '0;
        end else if (frame_tick) begin
            char_pos.x <= x_nxt;
            char_pos.y <= y_nxt;
            vy         <= vy_land;
        end
    end

endmodule

// ==== hw/draw_char.sv ====
`timescale 1ns/1ps

module draw_char (
    input  logic             clk,
    input  logic             rst_n,
    input  vga_pkg::vga_px_t px_in,
    input  game_pkg::point_t char_pos,
    output logic             hs,
    output logic             vs,
    output logic [3:0]       r,
    output logic [3:0]       g,
    output logic [3:0]       b
);
    import vga_pkg::*;
    import game_pkg::*;

    pos_t  px_x;
    pos_t  px_y;
    rect_t char_box;
    rgb_t  rgb_nxt;

    assign px_x     = to_pos(px_in.hcount);
    assign px_y     = to_pos(px_in.vcount);
    assign char_box = '{x: char_pos.x, y: char_pos.y, w: char_w, h: char_h};

    // character sits on top of everything drawn so far.
    always_comb begin
        if (px_in.hblnk || px_in.vblnk) begin
            rgb_nxt = '0;
        end else if (in_rect(px_x, px_y, char_box)) begin
            rgb_nxt = char_rgb;
        end else begin
            rgb_nxt = px_in.rgb;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hs        <= 1'b0;
            vs        <= 1'b0;
            {r, g, b} <= '0;
        end else begin
            hs        <= px_in.hsync;
            vs        <= px_in.vsync;
            {r, g, b} <= rgb_nxt;
        end
    end

endmodule

// ==== hw/top_vga.sv ====
`timescale 1ns/1ps

module top_vga #(
    parameter int              h_active = 640,
    parameter int              h_front  = 16,
    parameter int              h_sync   = 96,
    parameter int              h_back   = 48,
    parameter int              v_active = 480,
    parameter int              v_front  = 10,
    parameter int              v_sync   = 2,
    parameter int              v_back   = 33,
    parameter game_pkg::pos_t  floor_y  = 12'sd440,
    parameter game_pkg::rect_t plat     = '{x: 12'sd256, y: 12'sd360, w: 12'sd128, h: 12'sd8}
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           stepleft,
    input  logic           stepright,
    input  logic           stepjump,
    output logic           hs,
    output logic           vs,
    output logic [3:0]     r,
    output logic [3:0]     g,
    output logic [3:0]     b,
    output game_pkg::pos_t char_x,
    output game_pkg::pos_t char_y
);
    import vga_pkg::*;
    import game_pkg::*;

    vga_px_t tim_px;
    vga_px_t bg_px;
    vga_px_t plat_px;
    point_t  char_pos;
    logic    frame_tick;
    logic    on_ground;

    assign char_x = char_pos.x;
    assign char_y = char_pos.y;

    vga_timing #(
        .h_active(h_active),
        .h_front (h_front),
        .h_sync  (h_sync),
        .h_back  (h_back),
        .v_active(v_active),
        .v_front (v_front),
        .v_sync  (v_sync),
        .v_back  (v_back)
    ) u_vga_timing (
        .clk       (clk),
        .rst_n     (rst_n),
        .px        (tim_px),
        .frame_tick(frame_tick)
    );

    draw_bg #(
        .floor_y(floor_y)
    ) u_draw_bg (
        .clk   (clk),
        .rst_n (rst_n),
        .px_in (tim_px),
        .px_out(bg_px)
    );

    platform #(
        .plat   (plat),
        .floor_y(floor_y)
    ) u_platform (
        .clk      (clk),
        .rst_n    (rst_n),
        .px_in    (bg_px),
        .px_out   (plat_px),
        .char_pos (char_pos),
        .on_ground(on_ground)
    );

    char_ctl #(
        .h_active(h_active),
        .floor_y (floor_y),
        .plat    (plat)
    ) u_char_ctl (
        .clk       (clk),
        .rst_n     (rst_n),
        .frame_tick(frame_tick),
        .stepleft  (stepleft),
        .stepright (stepright),
        .stepjump  (stepjump),
        .on_ground (on_ground),
        .char_pos  (char_pos)
    );

    draw_char u_draw_char (
        .clk     (clk),
        .rst_n   (rst_n),
        .px_in   (plat_px),
        .char_pos(char_pos),
        .hs      (hs),
        .vs      (vs),
        .r       (r),
        .g       (g),
        .b       (b)
    );

endmodule

// ==== bench/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen #(
    parameter realtime period     = 40.0,
    parameter int      rst_cycles = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period / 2.0) clk = ~clk;
    end

    // release a little after the edge.
    initial begin
        rst_n = 1'b0;
        repeat (rst_cycles) @(posedge clk);
        #2 rst_n = 1'b1;
    end

endmodule

// ==== bench/top_vga_sva.sv ====
`timescale 1ns/1ps

module top_vga_sva #(
    parameter int h_active = 640,
    parameter int h_sync   = 96
) (
    input logic           clk,
    input logic           rst_n,
    input logic           hs,
    input logic           vs,
    input game_pkg::pos_t char_x,
    input game_pkg::pos_t char_y
);
    import game_pkg::*;

    localparam pos_t x_max = pos_t'(h_active) - char_w;

    int   fail_count = 0;
    pos_t x_q;
    pos_t y_q;
    logic vs_q;
    logic moved;
    logic frame_start;
    logic moved_in_frame;

    assign moved       = (char_x != x_q) || (char_y != y_q);
    assign frame_start = vs && !vs_q;

    // one cycle of history for position and vs.
    always_ff @(posedge clk) begin
        x_q  <= char_x;
        y_q  <= char_y;
        vs_q <= vs;
    end

    // a move already seen since the last vs rise.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            moved_in_frame <= 1'b0;
        end else if (frame_start) begin
            moved_in_frame <= moved;
        end else if (moved) begin
            moved_in_frame <= 1'b1;
        end
    end

    hs_width: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(hs) |-> hs [*h_sync] ##1 !hs)
    else begin
        $error("hs pulse width differs from %0d cycles", h_sync);
        fail_count++;
    end

    x_bound: assert property (@(posedge clk) disable iff (!rst_n)
        char_x >= 0 && char_x <= x_max)
    else begin
        $error("char_x %h outside 0..%h", char_x, x_max);
        fail_count++;
    end

    // at most one move between two vs rises.
    one_move: assert property (@(posedge clk) disable iff (!rst_n)
        moved && !frame_start |-> !moved_in_frame)
    else begin
        $error("character moved twice within one frame");
        fail_count++;
    end

endmodule

// ==== bench/top_vga_tb.sv ====
`timescale 1ns/1ps

module top_vga_tb;
    import vga_pkg::*;
    import game_pkg::*;

    localparam int h_active = 160;
    localparam int h_front  = 4;
    localparam int h_sync   = 8;
    localparam int h_back   = 4;
    localparam int v_active = 120;
    localparam int v_front  = 4;
    localparam int v_sync   = 8;
    localparam int v_back   = 4;
    localparam int h_total  = h_active + h_front + h_sync + h_back;
    localparam int v_total  = v_active + v_front + v_sync + v_back;
    localparam pos_t  floor_y = 12'sd100;
    localparam rect_t plat_r  = '{x: 12'sd40, y: 12'sd80, w: 12'sd48, h: 12'sd4};

    typedef struct packed {
        logic left;
        logic right;
        logic jump;
        pos_t x;
        pos_t y;
        logic pix;
    } step_t;

    logic clk;
    logic rst_n;
    logic stepleft;
    logic stepright;
    logic stepjump;
    logic hs;
    logic vs;
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
    pos_t char_x;
    pos_t char_y;

    step_t steps[$];
    longint cycles;
    longint limit;
    logic pix_en;
    int pix_hits;
    int pts_x[4];
    int pts_y[4];
    int exp_x;
    int exp_y;

    clk_gen #(.period(40.0), .rst_cycles(5)) clk_gen_i (.clk(clk), .rst_n(rst_n));

    top_vga #(
        .h_active(h_active), .h_front(h_front), .h_sync(h_sync), .h_back(h_back),
        .v_active(v_active), .v_front(v_front), .v_sync(v_sync), .v_back(v_back),
        .floor_y(floor_y), .plat(plat_r)
    ) dut_i (
        .clk(clk), .rst_n(rst_n),
        .stepleft(stepleft), .stepright(stepright), .stepjump(stepjump),
        .hs(hs), .vs(vs), .r(r), .g(g), .b(b),
        .char_x(char_x), .char_y(char_y)
    );

    bind top_vga top_vga_sva #(.h_active(h_active), .h_sync(h_sync)) sva_i (
        .clk(clk), .rst_n(rst_n), .hs(hs), .vs(vs),
        .char_x(char_x), .char_y(char_y)
    );

    task automatic fail_with(input string msg);
        $display("=== FAIL ===");
        $fatal(1, "%s", msg);
    endtask

    // character over platform over background.
    function automatic rgb_t colour_at(input int x, input int y, input int cx, input int cy);
        if (x >= cx && x < cx + char_w && y >= cy && y < cy + char_h)
            return char_rgb;
        if (x >= plat_r.x && x < plat_r.x + plat_r.w && y >= plat_r.y && y < plat_r.y + plat_r.h)
            return plat_rgb;
        if (y >= floor_y)
            return ground_rgb;
        return sky_rgb;
    endfunction

    task automatic read_steps;
        int fd;
        int n;
        int f[6];
        string line;
        fd = $fopen("bench/top_vga_stimulus.txt", "r");
        if (fd == 0)
            fail_with("could not open the stimulus file");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%d %d %d %d %d %d", f[0], f[1], f[2], f[3], f[4], f[5]);
                if (n == 6)
                    steps.push_back('{f[0][0], f[1][0], f[2][0], pos_t'(f[3]),
                                      pos_t'(f[4]), f[5][0]});
            end
        end
        $fclose(fd);
    endtask

    task automatic wait_vs_rise;
        logic prev;
        prev = vs;
        @(negedge clk);
        while (!(vs && !prev)) begin
            prev = vs;
            @(negedge clk);
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles >= limit)
            fail_with("timeout: the run did not finish in the expected number of cycles");
        if (dut_i.sva_i.fail_count != 0)
            fail_with("a bound assertion failed");
    end

    // raster tracking from the sync edges at the ports.
    always @(negedge clk) begin : raster
        static int cur_x = 0;
        static int cur_y = 0;
        static int h_period = 0;
        static int v_period = 0;
        static int hs_len = 0;
        static logic h_seen = 0;
        static logic v_seen = 0;
        static logic hs_q = 0;
        static logic vs_q = 0;
        rgb_t exp_c;
        if (rst_n) begin
            if (hs && !hs_q) begin
                if (h_seen)
                    assert (h_period == h_total) else
                        fail_with($sformatf("error: hs period %h, expected %h", h_period, h_total));
                h_period = 1;
                h_seen = 1;
                cur_x = h_active + h_front;
            end else begin
                h_period++;
                cur_x = (cur_x + 1) % h_total;
            end
            if (hs)
                hs_len++;
            if (!hs && hs_q) begin
                assert (hs_len == h_sync) else
                    fail_with($sformatf("error: hs width %h, expected %h", hs_len, h_sync));
                hs_len = 0;
            end
            if (vs && !vs_q) begin
                if (v_seen)
                    assert (v_period == h_total * v_total) else
                        fail_with($sformatf("error: vs period %h, expected %h",
                                            v_period, h_total * v_total));
                v_period = 1;
                v_seen = 1;
                cur_y = v_active + v_front;
            end else begin
                v_period++;
                if (cur_x == 0)
                    cur_y = (cur_y + 1) % v_total;
            end
            if (h_seen && v_seen && (cur_x >= h_active || cur_y >= v_active))
                assert ({r, g, b} == 12'h000) else
                    fail_with($sformatf("error: rgb %h in blanking, expected 000", {r, g, b}));
            if (pix_en && h_seen && v_seen) begin
                for (int k = 0; k < 4; k++) begin
                    if (cur_x == pts_x[k] && cur_y == pts_y[k]) begin
                        exp_c = colour_at(cur_x, cur_y, exp_x, exp_y);
                        assert ({r, g, b} == exp_c) else
                            fail_with($sformatf("error: rgb at %h,%h is %h, expected %h",
                                                cur_x, cur_y, {r, g, b}, exp_c));
                        pix_hits++;
                    end
                end
            end
            hs_q = hs;
            vs_q = vs;
        end
    end

    initial begin
        stepleft = 1'b0;
        stepright = 1'b0;
        stepjump = 1'b0;
        cycles = 0;
        limit = 0;
        pix_en = 1'b0;
        pix_hits = 0;
        exp_x = 0;
        exp_y = 0;
        read_steps();
        if (steps.size() == 0)
            fail_with("the stimulus file holds no frames");
        limit = (steps.size() + 2) * h_total * v_total;
        wait_vs_rise();
        for (int i = 0; i < steps.size(); i++) begin
            @(posedge clk);
            #2;
            stepleft = steps[i].left;
            stepright = steps[i].right;
            stepjump = steps[i].jump;
            // the last checked position is shown during this frame.
            if (i > 0 && steps[i - 1].pix) begin
                exp_x = steps[i - 1].x;
                exp_y = steps[i - 1].y;
                pts_x = '{exp_x, plat_r.x + plat_r.w / 2, 150, 150};
                pts_y = '{exp_y, plat_r.y + plat_r.h / 2, 0, v_active - 1};
                pix_hits = 0;
                pix_en = 1'b1;
            end
            wait_vs_rise();
            if (pix_en) begin
                assert (pix_hits == 4) else
                    fail_with("not every pixel position was seen in the frame");
                pix_en = 1'b0;
            end
            assert (char_x == steps[i].x) else
                fail_with($sformatf("error: char_x %h, expected %h", char_x, steps[i].x));
            assert (char_y == steps[i].y) else
                fail_with($sformatf("error: char_y %h, expected %h", char_y, steps[i].y));
        end
        if (dut_i.sva_i.fail_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            fail_with("a bound assertion failed");
        end
    end

endmodule

// ==== bench/top_vga_stimulus.txt ====
# left right jump, expected char_x and char_y after the frame, pixel check flag
# decimal fields, one frame per line
0 0 0 0 88 1
1 0 0 0 88 0
1 1 0 0 88 0
0 1 1 2 82 0
0 1 0 4 77 0
0 1 1 6 73 0
0 1 0 8 70 0
0 1 0 10 68 0
0 1 0 12 67 0
0 1 0 14 67 0
0 1 0 16 68 0
0 1 0 18 70 0
0 1 0 20 73 0
0 1 0 22 77 0
0 1 0 24 81 0
0 1 0 26 85 0
0 1 0 28 88 0
0 1 0 30 88 0
0 1 0 32 88 0
0 1 1 34 82 0
0 1 0 36 77 0
0 0 0 36 73 0
0 0 0 36 70 0
0 0 0 36 68 0
0 0 0 36 68 1
0 0 0 36 68 1
1 0 0 34 68 0
1 0 0 32 68 0
0 0 0 32 69 0
0 0 0 32 71 0
0 0 0 32 74 0
0 0 0 32 78 0
0 0 0 32 82 0
0 0 0 32 86 0
0 0 0 32 88 1
0 0 0 32 88 0

// ==== sources.f ====
hw/vga_pkg.sv
hw/game_pkg.sv
hw/vga_timing.sv
hw/draw_bg.sv
hw/platform.sv
hw/char_ctl.sv
hw/draw_char.sv
hw/top_vga.sv
bench/clk_gen.sv
bench/top_vga_sva.sv
bench/top_vga_tb.sv
